//--- verilog/render_pkg.sv
package render_pkg;

    // Screen geometry
    localparam int SCREEN_W  = 320;
    localparam int SCREEN_H  = 240;
    localparam int PIXELS    = SCREEN_W * SCREEN_H;
    localparam int SPLIT_COL = 159;
    localparam int LINE_BASE = SPLIT_COL * SCREEN_H;

    // Sprite geometry and the ROM image behind it
    localparam int    SPRITE_W     = 8;
    localparam int    SPRITE_H     = 8;
    localparam int    SPRITE_COUNT = 4;
    localparam string SPRITE_FILE  = "verilog/sprites.mem";

    // Texture code decode
    localparam int FILL_FLAG_BIT = 6;
    localparam int SPLIT_CODE    = 31;

    // Frame timing and colour expansion
    localparam int FLUSH_PERIOD = 100000;
    localparam int FRAME_CNT_W  = $clog2(FLUSH_PERIOD + 1);
    localparam int COLOR_SCALE  = 85;

    // CPU register map
    localparam logic [3:0] REG_MID_X  = 4'd1;
    localparam logic [3:0] REG_MID_Y  = 4'd2;
    localparam logic [3:0] REG_NEG    = 4'd3;
    localparam logic [3:0] REG_TEX    = 4'd4;
    localparam logic [3:0] REG_PARITY = 4'd5;
    localparam logic [3:0] REG_GO     = 4'd6;

    // RR_GG_BB
    typedef logic [5:0] color_t;
    // Draw flag above the colour bits
    typedef logic [6:0] texel_t;
    typedef logic signed [9:0] coord_t;
    // Column * SCREEN_H + row
    typedef logic [16:0] fb_addr_t;
    typedef logic [6:0] tex_code_t;
    typedef logic [4:0] tex_addr_t;
    // One sprite column, row 0 in the low texel
    typedef logic [55:0] tex_word_t;

    typedef enum logic [1:0] {PLOT_FILL, PLOT_SPRITE, PLOT_LINE} plot_kind_t;
    typedef enum logic [1:0] {IDLE, PLOT, FLUSH} ctrl_state_t;

endpackage

//--- verilog/frame_ram.sv
`timescale 1ns/100ps

module frame_ram
    import render_pkg::*;
(
    input  logic     clk,
    input  logic     wr_en,
    input  fb_addr_t wr_addr,
    input  color_t   wr_data,
    input  fb_addr_t rd_addr,
    output color_t   rd_data
);

    // Column-major, one colour per pixel
    color_t mem [PIXELS];

    always_ff @(posedge clk) begin
        if (wr_en)
            mem[wr_addr] <= wr_data;
        rd_data <= mem[rd_addr];
    end

endmodule

//--- verilog/texture_rom.sv
`timescale 1ns/100ps

module texture_rom
    import render_pkg::*;
(
    input  logic      clk,
    input  tex_addr_t tex_addr,
    output tex_word_t tex_word
);

    // Sprite s, column c lives at s * SPRITE_W + c
    tex_word_t rom [SPRITE_COUNT * SPRITE_W];

    initial begin
        $readmemh(SPRITE_FILE, rom);
    end

    always_ff @(posedge clk) begin
        tex_word <= rom[tex_addr];
    end

endmodule

//--- verilog/render_ctrl.sv
`timescale 1ns/100ps

module render_ctrl
    import render_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic [3:0]  address,
    input  logic        read,
    input  logic        write,
    input  logic [31:0] writedata,
    output logic [31:0] readdata,
    output logic        waitrequest,
    output logic        plot_start,
    output plot_kind_t  plot_kind,
    output color_t      fill_color,
    output logic [1:0]  sprite_index,
    output coord_t      mid_x,
    output coord_t      mid_y,
    input  logic        plot_done,
    output logic        flush_start,
    input  logic        flush_done
);

    ctrl_state_t            state;
    tex_code_t              tex_code;
    logic                   neg_flag;
    logic                   parity;
    logic [FRAME_CNT_W-1:0] frame_cnt;
    logic                   flush_due;
    logic                   kind_valid;
    logic                   cpu_read;
    logic                   cpu_write;
    logic                   go;

    // Accesses only land while the port is not stalled
    assign cpu_read  = read && !waitrequest;
    assign cpu_write = write && !waitrequest;
    assign go        = cpu_write && (address == REG_GO);
    assign flush_due = (frame_cnt == FRAME_CNT_W'(FLUSH_PERIOD));

    // Texture code decode
    always_comb begin
        plot_kind  = PLOT_SPRITE;
        kind_valid = 1'b1;
        if (tex_code[FILL_FLAG_BIT])
            plot_kind = PLOT_FILL;
        else if (tex_code == tex_code_t'(SPLIT_CODE))
            plot_kind = PLOT_LINE;
        else if (tex_code == '0 || tex_code > tex_code_t'(SPRITE_COUNT))
            kind_valid = 1'b0;
    end

    assign fill_color   = color_t'(tex_code);
    // Codes 1 to 4 map to sprites 0 to 3
    assign sprite_index = 2'(tex_code - 7'd1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mid_x    <= '0;
            mid_y    <= '0;
            neg_flag <= 1'b0;
            tex_code <= '0;
            readdata <= '0;
        end else begin
            if (cpu_write) begin
                case (address)
                    REG_MID_X: mid_x <= neg_flag ? -coord_t'({1'b0, writedata[8:0]})
                                                 : coord_t'({1'b0, writedata[8:0]});
                    REG_MID_Y: mid_y <= neg_flag ? -coord_t'({2'b0, writedata[7:0]})
                                                 : coord_t'({2'b0, writedata[7:0]});
                    REG_NEG:   neg_flag <= writedata[0];
                    REG_TEX:   tex_code <= writedata[6:0];
                    default:   ;
                endcase
            end
            if (cpu_read && address == REG_PARITY)
                readdata <= {31'b0, parity};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= IDLE;
            waitrequest <= 1'b0;
            plot_start  <= 1'b0;
            flush_start <= 1'b0;
            parity      <= 1'b0;
            frame_cnt   <= '0;
        end else begin
            plot_start  <= 1'b0;
            flush_start <= 1'b0;
            // Frame counter saturates until the flush takes it
            if (state != FLUSH && !flush_due)
                frame_cnt <= frame_cnt + 1'b1;
            case (state)
                IDLE: begin
                    if (go) begin
                        // Unknown codes stall for one cycle only
                        waitrequest <= 1'b1;
                        plot_start  <= kind_valid;
                        if (kind_valid)
                            state <= PLOT;
                    end else if (flush_due) begin
                        waitrequest <= 1'b1;
                        flush_start <= 1'b1;
                        state       <= FLUSH;
                    end else begin
                        waitrequest <= 1'b0;
                    end
                end
                PLOT: begin
                    if (plot_done) begin
                        if (flush_due) begin
                            // Deferred flush goes straight on
                            flush_start <= 1'b1;
                            state       <= FLUSH;
                        end else begin
                            waitrequest <= 1'b0;
                            state       <= IDLE;
                        end
                    end
                end
                FLUSH: begin
                    if (flush_done) begin
                        parity      <= ~parity;
                        frame_cnt   <= '0;
                        waitrequest <= 1'b0;
                        state       <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // CPU stays stalled for the whole of a plot or flush
    assert property (@(posedge clk) disable iff (!rst_n)
        (state == PLOT || state == FLUSH) |-> waitrequest);

    // No plot can overlap the buffer copy
    assert property (@(posedge clk) disable iff (!rst_n)
        plot_start |-> (state != FLUSH) && !flush_start);

endmodule

//--- verilog/plot_engine.sv
`timescale 1ns/100ps

module plot_engine
    import render_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       plot_start,
    input  plot_kind_t plot_kind,
    input  color_t     fill_color,
    input  logic [1:0] sprite_index,
    input  coord_t     mid_x,
    input  coord_t     mid_y,
    output logic       plot_done,
    output tex_addr_t  tex_addr,
    input  tex_word_t  tex_word,
    output logic       wr_en,
    output fb_addr_t   wr_addr,
    output color_t     wr_data
);

    logic       lin_busy;
    fb_addr_t   lin_last;
    logic       spr_busy;
    logic [2:0] col;
    logic [3:0] step;
    coord_t     pix_x;
    coord_t     pix_y;
    logic       on_screen;
    logic       stg_valid;
    logic       stg_last;
    logic [2:0] stg_row;
    fb_addr_t   stg_addr;
    texel_t     texel;

    // One ROM word per sprite column
    assign tex_addr = {sprite_index, col};

    // Screen position of the walker, centred on mid
    assign pix_x = mid_x + coord_t'(col) - coord_t'(SPRITE_W / 2);
    assign pix_y = mid_y + coord_t'(step) - coord_t'(SPRITE_H / 2);
    assign on_screen = (pix_x >= 0) && (pix_x < SCREEN_W) &&
                       (pix_y >= 0) && (pix_y < SCREEN_H);

    // Sprite walker where step SPRITE_H is the gap to the next column
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            spr_busy <= 1'b0;
            col      <= '0;
            step     <= '0;
        end else if (plot_start && plot_kind == PLOT_SPRITE) begin
            spr_busy <= 1'b1;
            col      <= '0;
            step     <= '0;
        end else if (spr_busy) begin
            if (step == 4'(SPRITE_H)) begin
                step <= '0;
                col  <= col + 1'b1;
                if (col == 3'(SPRITE_W - 1))
                    spr_busy <= 1'b0;
            end else begin
                step <= step + 1'b1;
            end
        end
    end

    // Row position delayed one cycle to line up with the ROM word
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stg_valid <= 1'b0;
            stg_last  <= 1'b0;
        end else begin
            stg_valid <= spr_busy && (step < 4'(SPRITE_H)) && on_screen;
            stg_last  <= spr_busy && (step == 4'(SPRITE_H)) && (col == 3'(SPRITE_W - 1));
        end
    end

    always_ff @(posedge clk) begin
        stg_row  <= step[2:0];
        stg_addr <= fb_addr_t'(pix_x) * fb_addr_t'(SCREEN_H) + fb_addr_t'(pix_y);
    end

    assign texel = tex_word[stg_row * $bits(texel_t) +: $bits(texel_t)];

    // Back-buffer write port shared by the linear walk and the sprite pipe
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lin_busy  <= 1'b0;
            lin_last  <= '0;
            plot_done <= 1'b0;
            wr_en     <= 1'b0;
            wr_addr   <= '0;
            wr_data   <= '0;
        end else begin
            plot_done <= stg_last;
            if (plot_start && plot_kind != PLOT_SPRITE) begin
                lin_busy <= 1'b1;
                wr_en    <= 1'b1;
                if (plot_kind == PLOT_FILL) begin
                    wr_addr  <= '0;
                    lin_last <= fb_addr_t'(PIXELS - 1);
                    wr_data  <= fill_color;
                end else begin
                    // Split line is black
                    wr_addr  <= fb_addr_t'(LINE_BASE);
                    lin_last <= fb_addr_t'(LINE_BASE + SCREEN_H - 1);
                    wr_data  <= '0;
                end
            end else if (lin_busy) begin
                if (wr_addr == lin_last) begin
                    lin_busy  <= 1'b0;
                    wr_en     <= 1'b0;
                    plot_done <= 1'b1;
                end else begin
                    wr_addr <= wr_addr + 1'b1;
                end
            end else begin
                wr_en   <= stg_valid && texel[$bits(color_t)];
                wr_addr <= stg_addr;
                wr_data <= texel[$bits(color_t)-1:0];
            end
        end
    end

    // Clipping keeps every write inside the frame
    assert property (@(posedge clk) disable iff (!rst_n)
        wr_en |-> (wr_addr < fb_addr_t'(PIXELS)));

endmodule

//--- verilog/buffer_flusher.sv
`timescale 1ns/100ps

module buffer_flusher
    import render_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     flush_start,
    output logic     flush_done,
    output fb_addr_t rd_addr,
    input  color_t   rd_data,
    output logic     wr_en,
    output fb_addr_t wr_addr,
    output color_t   wr_data
);

    logic     rd_busy;
    fb_addr_t wr_count;

    // Read data lands in the front buffer the cycle it returns
    assign wr_data = rd_data;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_busy    <= 1'b0;
            rd_addr    <= '0;
            wr_en      <= 1'b0;
            wr_addr    <= '0;
            flush_done <= 1'b0;
            wr_count   <= '0;
        end else begin
            // Write stage trails the read address by one
            wr_en      <= rd_busy;
            wr_addr    <= rd_addr;
            flush_done <= wr_en && (wr_addr == fb_addr_t'(PIXELS - 1));
            if (flush_start) begin
                rd_busy  <= 1'b1;
                rd_addr  <= '0;
                wr_count <= '0;
            end else begin
                if (wr_en)
                    wr_count <= wr_count + 1'b1;
                if (rd_busy) begin
                    if (rd_addr == fb_addr_t'(PIXELS - 1))
                        rd_busy <= 1'b0;
                    else
                        rd_addr <= rd_addr + 1'b1;
                end
            end
        end
    end

    // No more than one frame of writes per flush
    assert property (@(posedge clk) disable iff (!rst_n)
        wr_en |-> (wr_count < fb_addr_t'(PIXELS)));

endmodule

//--- verilog/scanout.sv
`timescale 1ns/100ps

module scanout
    import render_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic [8:0] pixel_x,
    input  logic [7:0] pixel_y,
    output logic [7:0] red,
    output logic [7:0] green,
    output logic [7:0] blue,
    input  logic       wr_en,
    input  fb_addr_t   wr_addr,
    input  color_t     wr_data
);

    fb_addr_t rd_addr;
    color_t   pix;

    assign rd_addr = fb_addr_t'(pixel_x) * fb_addr_t'(SCREEN_H) + fb_addr_t'(pixel_y);

    frame_ram front_buffer (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_addr (rd_addr),
        .rd_data (pix)
    );

    // 2-bit channel times 85 spans 0 to 255
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            red   <= '0;
            green <= '0;
            blue  <= '0;
        end else begin
            red   <= 8'(pix[5:4] * COLOR_SCALE);
            green <= 8'(pix[3:2] * COLOR_SCALE);
            blue  <= 8'(pix[1:0] * COLOR_SCALE);
        end
    end

endmodule

//--- verilog/render_top.sv
`timescale 1ns/100ps

module render_top
    import render_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic [3:0]  address,
    input  logic        read,
    input  logic        write,
    input  logic [31:0] writedata,
    output logic [31:0] readdata,
    output logic        waitrequest,
    input  logic [8:0]  pixel_x,
    input  logic [7:0]  pixel_y,
    output logic [7:0]  red,
    output logic [7:0]  green,
    output logic [7:0]  blue
);

    logic       plot_start;
    logic       plot_done;
    plot_kind_t plot_kind;
    color_t     fill_color;
    logic [1:0] sprite_index;
    coord_t     mid_x;
    coord_t     mid_y;
    logic       flush_start;
    logic       flush_done;

    tex_addr_t  tex_addr;
    tex_word_t  tex_word;

    // Back buffer written by the plot engine and read by the flusher
    logic       back_wr_en;
    fb_addr_t   back_wr_addr;
    color_t     back_wr_data;
    fb_addr_t   back_rd_addr;
    color_t     back_rd_data;

    // Flusher into the front buffer
    logic       front_wr_en;
    fb_addr_t   front_wr_addr;
    color_t     front_wr_data;

    render_ctrl u_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .address      (address),
        .read         (read),
        .write        (write),
        .writedata    (writedata),
        .readdata     (readdata),
        .waitrequest  (waitrequest),
        .plot_start   (plot_start),
        .plot_kind    (plot_kind),
        .fill_color   (fill_color),
        .sprite_index (sprite_index),
        .mid_x        (mid_x),
        .mid_y        (mid_y),
        .plot_done    (plot_done),
        .flush_start  (flush_start),
        .flush_done   (flush_done)
    );

    plot_engine u_plot (
        .clk          (clk),
        .rst_n        (rst_n),
        .plot_start   (plot_start),
        .plot_kind    (plot_kind),
        .fill_color   (fill_color),
        .sprite_index (sprite_index),
        .mid_x        (mid_x),
        .mid_y        (mid_y),
        .plot_done    (plot_done),
        .tex_addr     (tex_addr),
        .tex_word     (tex_word),
        .wr_en        (back_wr_en),
        .wr_addr      (back_wr_addr),
        .wr_data      (back_wr_data)
    );

    texture_rom u_rom (
        .clk      (clk),
        .tex_addr (tex_addr),
        .tex_word (tex_word)
    );

    frame_ram back_buffer (
        .clk     (clk),
        .wr_en   (back_wr_en),
        .wr_addr (back_wr_addr),
        .wr_data (back_wr_data),
        .rd_addr (back_rd_addr),
        .rd_data (back_rd_data)
    );

    buffer_flusher u_flush (
        .clk         (clk),
        .rst_n       (rst_n),
        .flush_start (flush_start),
        .flush_done  (flush_done),
        .rd_addr     (back_rd_addr),
        .rd_data     (back_rd_data),
        .wr_en       (front_wr_en),
        .wr_addr     (front_wr_addr),
        .wr_data     (front_wr_data)
    );

    scanout u_scan (
        .clk     (clk),
        .rst_n   (rst_n),
        .pixel_x (pixel_x),
        .pixel_y (pixel_y),
        .red     (red),
        .green   (green),
        .blue    (blue),
        .wr_en   (front_wr_en),
        .wr_addr (front_wr_addr),
        .wr_data (front_wr_data)
    );

endmodule

//--- tb/render_tb.sv
`timescale 1ns/100ps

module render_tb
    import render_pkg::*;
();

    logic        clk;
    logic        rst_n;
    logic [3:0]  address;
    logic        read;
    logic        write;
    logic [31:0] writedata;
    logic [31:0] readdata;
    logic        waitrequest;
    logic [8:0]  pixel_x;
    logic [7:0]  pixel_y;
    logic [7:0]  red;
    logic [7:0]  green;
    logic [7:0]  blue;

    // Parsed command list
    byte cmd_q[$];
    int  arg_a[$];
    int  arg_b[$];
    int  arg_c[$];
    int  frame_waits;
    int  cycles;
    int  cycle_limit;

    render_top UUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .address     (address),
        .read        (read),
        .write       (write),
        .writedata   (writedata),
        .readdata    (readdata),
        .waitrequest (waitrequest),
        .pixel_x     (pixel_x),
        .pixel_y     (pixel_y),
        .red         (red),
        .green       (green),
        .blue        (blue)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input int got, input int expected);
        $display("Fail at %0d ns: %s is %0d, expected %0d", $time, name, got, expected);
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    task automatic load_tests();
        int    fd;
        int    n;
        int    a;
        int    b;
        int    c;
        byte   kind;
        string line;
        fd = $fopen("tb/render_tests.txt", "r");
        if (fd == 0)
            abort_run("cannot open the tests file tb/render_tests.txt");
        while ($fgets(line, fd) != 0) begin
            kind = line.getc(0);
            if (kind == "#" || kind == "\n" || kind == "\r")
                continue;
            a = 0;
            b = 0;
            c = 0;
            case (kind)
                "W": n = ($sscanf(line, "W %h %h", a, b) == 2) ? 1 : 0;
                "F": n = 1;
                "P": n = ($sscanf(line, "P %d %d %h", a, b, c) == 3) ? 1 : 0;
                default: n = 0;
            endcase
            if (n == 0)
                abort_run($sformatf("unreadable line in the tests file: %s", line));
            cmd_q.push_back(kind);
            arg_a.push_back(a);
            arg_b.push_back(b);
            arg_c.push_back(c);
            if (kind == "F")
                frame_waits++;
        end
        $fclose(fd);
    endtask

    // Returns just after the edge that took the access
    task automatic hold_until_accepted();
        logic accepted;
        accepted = 1'b0;
        while (!accepted) begin
            @(negedge clk);
            accepted = !waitrequest;
            @(posedge clk);
        end
    endtask

    task automatic write_reg(input logic [3:0] addr, input logic [31:0] data);
        @(posedge clk);
        address   <= addr;
        writedata <= data;
        write     <= 1'b1;
        hold_until_accepted();
        write <= 1'b0;
    endtask

    task automatic read_parity(output logic value);
        @(posedge clk);
        address <= REG_PARITY;
        read    <= 1'b1;
        hold_until_accepted();
        read <= 1'b0;
        // readdata is registered on the accepting edge
        @(negedge clk);
        assert (readdata[31:1] == '0)
            else report_mismatch("readdata[31:1]", int'(readdata[31:1]), 0);
        value = readdata[0];
    endtask

    task automatic wait_frame();
        logic start_parity;
        logic now_parity;
        read_parity(start_parity);
        now_parity = start_parity;
        while (now_parity == start_parity)
            read_parity(now_parity);
    endtask

    task automatic probe_pixel(input int x, input int y, input logic [5:0] color);
        int    exp_red;
        int    exp_green;
        int    exp_blue;
        string where;
        exp_red   = int'(color[5:4]) * COLOR_SCALE;
        exp_green = int'(color[3:2]) * COLOR_SCALE;
        exp_blue  = int'(color[1:0]) * COLOR_SCALE;
        where     = $sformatf("at pixel (%0d,%0d)", x, y);
        @(posedge clk);
        pixel_x <= 9'(x);
        pixel_y <= 8'(y);
        // RAM read, then the output register
        repeat (2) @(posedge clk);
        @(negedge clk);
        assert (int'(red) == exp_red)
            else report_mismatch({"red ", where}, red, exp_red);
        assert (int'(green) == exp_green)
            else report_mismatch({"green ", where}, green, exp_green);
        assert (int'(blue) == exp_blue)
            else report_mismatch({"blue ", where}, blue, exp_blue);
    endtask

    initial begin
        cycles = 0;
        @(posedge clk);
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        abort_run("timeout: render did not finish the tests");
    end

    initial begin
        rst_n       = 1'b0;
        address     = '0;
        read        = 1'b0;
        write       = 1'b0;
        writedata   = '0;
        pixel_x     = '0;
        pixel_y     = '0;
        frame_waits = 0;
        load_tests();
        cycle_limit = (frame_waits + 2) * (FLUSH_PERIOD + 2 * PIXELS + 1000);
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        foreach (cmd_q[i]) begin
            case (cmd_q[i])
                "W":     write_reg(4'(arg_a[i]), 32'(arg_b[i]));
                "F":     wait_frame();
                default: probe_pixel(arg_a[i], arg_b[i], 6'(arg_c[i]));
            endcase
        end
        $display("=== PASS ===");
        $finish;
    end

endmodule

//--- verilog/sprites.mem
// Sprite s column c sits on word s*8+c, one 7-bit texel per row with row 0 lowest
// Sprite 0, red checker, opaque where column plus row is even
01C007001C0070
E003800E003800
01C007001C0070
E003800E003800
01C007001C0070
E003800E003800
01C007001C0070
E003800E003800
// Sprite 1, green checker in the opposite phase
98026009802600
013004C013004C
98026009802600
013004C013004C
98026009802600
013004C013004C
98026009802600
013004C013004C
// Sprite 2, blue stripes on the even rows
010C043010C043
010C043010C043
010C043010C043
010C043010C043
010C043010C043
010C043010C043
010C043010C043
010C043010C043
// Sprite 3, solid white
FFFFFFFFFFFFFF
FFFFFFFFFFFFFF
FFFFFFFFFFFFFF
FFFFFFFFFFFFFF
FFFFFFFFFFFFFF
FFFFFFFFFFFFFF
FFFFFFFFFFFFFF
FFFFFFFFFFFFFF

//--- tb/render_tests.txt
# W <reg> <value> writes a register, both hex; F waits for the next frame
# P <x> <y> <colour> probes a pixel, x and y decimal, colour hex
# Fill 0x2D, then corners and centre
W 4 6D
W 6 0
F
P 0 0 2D
P 319 0 2D
P 0 239 2D
P 319 239 2D
P 160 120 2D
# Fill 0x15 and draw the red checker sprite at (100,100)
W 4 55
W 6 0
W 1 64
W 2 64
W 4 1
W 6 0
# White sprite at (-2,50), only columns 0 and 1 land on screen
W 3 1
W 1 2
W 3 0
W 2 32
W 4 4
W 6 0
# Split line
W 4 1F
W 6 0
F
P 96 96 30
P 97 96 15
P 100 100 30
P 103 96 15
P 103 103 30
P 95 100 15
P 104 100 15
P 100 95 15
P 100 104 15
P 0 46 3F
P 1 53 3F
P 2 50 15
P 0 45 15
P 0 54 15
P 319 50 15
P 159 0 0
P 159 120 0
P 159 239 0
P 158 120 15
P 160 120 15
# Code 10 draws nothing
W 4 A
W 6 0
F
P 100 100 30
P 97 96 15
P 159 10 0
# Frame held with no commands
F
P 100 100 30
P 0 47 3F
P 160 120 15

//--- flist.f
verilog/render_pkg.sv
verilog/frame_ram.sv
verilog/texture_rom.sv
verilog/render_ctrl.sv
verilog/plot_engine.sv
verilog/buffer_flusher.sv
verilog/scanout.sv
verilog/render_top.sv
tb/render_tb.sv

//--- Makefile
SIM  := obj_dir/Vrender_tb
SRCS := $(shell cat flist.f)

all: run

$(SIM): flist.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module render_tb -f flist.f

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '=== PASS ==='

clean:
	rm -rf obj_dir

.PHONY: all run clean
